// File: design/icache_cfg_pkg.sv
`default_nettype none

package icache_cfg_pkg;

    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 4;
    localparam int SETS       = 64;
    localparam int WAYS       = 2;

    // address split is tag | index | offset | byte
    localparam int BYTE_W    = $clog2(WORD_W / 8);
    localparam int OFFSET_W  = $clog2(LINE_WORDS);
    localparam int INDEX_W   = $clog2(SETS);
    localparam int TAG_W     = ADDR_W - INDEX_W - OFFSET_W - BYTE_W;
    localparam int WAY_W     = $clog2(WAYS);
    localparam int INDEX_LSB = BYTE_W + OFFSET_W;
    localparam int TAG_LSB   = INDEX_LSB + INDEX_W;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [OFFSET_W-1:0] offset_t;
    typedef logic [WAY_W-1:0]    way_t;
    typedef logic                op_t;

    localparam op_t OP_FETCH = 1'b0;
    localparam op_t OP_INVAL = 1'b1;

    // victim LFSR, must not start at zero
    localparam int                LFSR_W    = 8;
    localparam logic [LFSR_W-1:0] LFSR_SEED = 8'hA5;

    typedef struct packed {
        op_t   op;
        addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        addr_t addr;
        word_t inst;
    } fetch_resp_t;

    typedef struct packed {
        logic    data_we;
        logic    tag_we;
        logic    inval;
        way_t    way;
        index_t  index;
        offset_t offset;
        word_t   word;
        tag_t    tag;
    } array_wr_t;

    function automatic index_t addr_index(input addr_t addr);
        return addr[INDEX_LSB +: INDEX_W];
    endfunction

    function automatic tag_t addr_tag(input addr_t addr);
        return addr[TAG_LSB +: TAG_W];
    endfunction

    function automatic offset_t addr_offset(input addr_t addr);
        return addr[BYTE_W +: OFFSET_W];
    endfunction

endpackage

`default_nettype wire

// File: design/icache_bus_pkg.sv
`default_nettype none

package icache_bus_pkg;

    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;

    // classic cycle, master side
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [WB_DAT_W-1:0] dat;
    } wb_rsp_t;

    // bus parked between refills
    localparam wb_req_t WB_REQ_IDLE = '{cyc: 1'b0, stb: 1'b0, we: 1'b0, adr: '0};

endpackage

`default_nettype wire

// File: design/fetch_decode.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_decode (
    input  wire                         clk,
    input  wire                         rst_n,

    input  icache_cfg_pkg::fetch_req_t  req_i,
    input  wire                         req_valid_i,
    output logic                        req_ready_o,

    input  wire                         advance_i,
    input  wire                         busy_i,

    output logic                        dec_valid_o,
    output icache_cfg_pkg::fetch_req_t  dec_req_o,
    output icache_cfg_pkg::index_t      rd_index_o
);

    logic                       dec_valid_q;
    icache_cfg_pkg::fetch_req_t dec_req_q;
    logic                       accept;

    // take a new one when empty or when the held one leaves this edge
    assign req_ready_o = !busy_i && (!dec_valid_q || advance_i);
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid_q <= 1'b0;
        end else if (accept) begin
            dec_valid_q <= 1'b1;
        end else if (advance_i) begin
            dec_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_req_q <= req_i;
        end
    end

    // keep reading the held set under a stall so the ways stay aligned
    always_comb begin
        if (accept) begin
            rd_index_o = icache_cfg_pkg::addr_index(req_i.addr);
        end else begin
            rd_index_o = icache_cfg_pkg::addr_index(dec_req_q.addr);
        end
    end

    assign dec_valid_o = dec_valid_q;
    assign dec_req_o   = dec_req_q;

endmodule

`default_nettype wire

// File: design/cache_ways.sv
`timescale 1ns/100ps
`default_nettype none

module cache_ways (
    input  wire                        clk,
    input  wire                        rst_n,

    input  icache_cfg_pkg::index_t     rd_index_i,
    input  icache_cfg_pkg::array_wr_t  wr_i,

    output icache_cfg_pkg::tag_t  [icache_cfg_pkg::WAYS-1:0] tag_o,
    output logic                  [icache_cfg_pkg::WAYS-1:0] valid_o,
    output icache_cfg_pkg::word_t [icache_cfg_pkg::WAYS-1:0][icache_cfg_pkg::LINE_WORDS-1:0] data_o
);

    icache_cfg_pkg::tag_t  tag_mem  [icache_cfg_pkg::WAYS][icache_cfg_pkg::SETS];
    icache_cfg_pkg::word_t data_mem [icache_cfg_pkg::WAYS][icache_cfg_pkg::SETS]
                                    [icache_cfg_pkg::LINE_WORDS];

    logic [icache_cfg_pkg::WAYS-1:0][icache_cfg_pkg::SETS-1:0] valid_q;

    // tag and data arrays, read returns the old contents on a same-set write
    always_ff @(posedge clk) begin
        for (int w = 0; w < icache_cfg_pkg::WAYS; w++) begin
            if (wr_i.data_we && wr_i.way == icache_cfg_pkg::way_t'(w)) begin
                data_mem[w][wr_i.index][wr_i.offset] <= wr_i.word;
            end
            if (wr_i.tag_we && wr_i.way == icache_cfg_pkg::way_t'(w)) begin
                tag_mem[w][wr_i.index] <= wr_i.tag;
            end
            tag_o[w] <= tag_mem[w][rd_index_i];
            for (int o = 0; o < icache_cfg_pkg::LINE_WORDS; o++) begin
                data_o[w][o] <= data_mem[w][rd_index_i][o];
            end
        end
    end

    // valid bits live in flops so reset can clear every set
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            valid_o <= '0;
        end else begin
            for (int w = 0; w < icache_cfg_pkg::WAYS; w++) begin
                if (wr_i.inval) begin
                    valid_q[w][wr_i.index] <= 1'b0;
                end else if (wr_i.tag_we && wr_i.way == icache_cfg_pkg::way_t'(w)) begin
                    valid_q[w][wr_i.index] <= 1'b1;
                end
                valid_o[w] <= valid_q[w][rd_index_i];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/refill_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module refill_ctrl (
    input  wire                         clk,
    input  wire                         rst_n,

    input  wire                         dec_valid_i,
    input  icache_cfg_pkg::fetch_req_t  dec_req_i,
    input  wire                         hit_i,

    output logic                        busy_o,
    output logic                        done_o,
    output icache_cfg_pkg::word_t       fill_word_o,
    output icache_cfg_pkg::array_wr_t   wr_o,

    output icache_bus_pkg::wb_req_t     wb_o,
    input  icache_bus_pkg::wb_rsp_t     wb_i
);

    typedef enum logic [1:0] {
        IDLE,
        INVAL,
        READ,
        DONE
    } state_t;

    state_t                                 state_q;
    state_t                                 state_d;
    icache_cfg_pkg::fetch_req_t             req_q;
    icache_cfg_pkg::offset_t                cnt_q;
    icache_cfg_pkg::word_t                  fill_q;
    logic [icache_cfg_pkg::LFSR_W-1:0]      lfsr_q;
    logic                                   lfsr_fb;
    icache_cfg_pkg::way_t                   victim;
    logic                                   start_miss;
    logic                                   start_inval;
    logic                                   beat_ack;
    logic                                   last_ack;

    assign start_inval = (state_q == IDLE) && dec_valid_i
                         && (dec_req_i.op == icache_cfg_pkg::OP_INVAL);
    assign start_miss  = (state_q == IDLE) && dec_valid_i
                         && (dec_req_i.op == icache_cfg_pkg::OP_FETCH) && !hit_i;
    assign beat_ack    = (state_q == READ) && wb_i.ack;
    assign last_ack    = beat_ack
                         && (cnt_q == icache_cfg_pkg::offset_t'(icache_cfg_pkg::LINE_WORDS - 1));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_inval) begin
                    state_d = INVAL;
                end else if (start_miss) begin
                    state_d = READ;
                end
            end
            INVAL: state_d = IDLE;
            READ: begin
                if (last_ack) begin
                    state_d = DONE;
                end
            end
            DONE: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE) begin
                cnt_q <= '0;
            end else if (beat_ack) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    // decode holds its request until we are done, so sampling in idle is enough
    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            req_q <= dec_req_i;
        end
        if (beat_ack && cnt_q == icache_cfg_pkg::addr_offset(req_q.addr)) begin
            fill_q <= wb_i.dat;
        end
    end

    // x^8 + x^6 + x^5 + x^4 + 1, one step per finished refill
    assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
    assign victim  = lfsr_q[icache_cfg_pkg::WAY_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr_q <= icache_cfg_pkg::LFSR_SEED;
        end else if (last_ack) begin
            lfsr_q <= {lfsr_q[icache_cfg_pkg::LFSR_W-2:0], lfsr_fb};
        end
    end

    // one classic read per word, cyc held across the whole line
    always_comb begin
        wb_o = icache_bus_pkg::WB_REQ_IDLE;
        if (state_q == READ) begin
            wb_o.cyc = 1'b1;
            wb_o.stb = 1'b1;
            wb_o.adr = {req_q.addr[icache_cfg_pkg::ADDR_W-1:icache_cfg_pkg::INDEX_LSB],
                        cnt_q, {icache_cfg_pkg::BYTE_W{1'b0}}};
        end
    end

    always_comb begin
        wr_o.data_we = beat_ack;
        wr_o.tag_we  = last_ack;
        wr_o.inval   = (state_q == INVAL);
        wr_o.way     = victim;
        wr_o.index   = icache_cfg_pkg::addr_index(req_q.addr);
        wr_o.offset  = cnt_q;
        wr_o.word    = wb_i.dat;
        wr_o.tag     = icache_cfg_pkg::addr_tag(req_q.addr);
    end

    assign busy_o      = (state_q != IDLE) || start_miss || start_inval;
    assign done_o      = (state_q == DONE);
    assign fill_word_o = fill_q;

endmodule

`default_nettype wire

// File: design/hit_select.sv
`timescale 1ns/100ps
`default_nettype none

module hit_select (
    input  wire                         clk,
    input  wire                         rst_n,

    input  wire                         dec_valid_i,
    input  icache_cfg_pkg::fetch_req_t  dec_req_i,

    input  icache_cfg_pkg::tag_t  [icache_cfg_pkg::WAYS-1:0] tag_i,
    input  wire                   [icache_cfg_pkg::WAYS-1:0] valid_i,
    input  icache_cfg_pkg::word_t [icache_cfg_pkg::WAYS-1:0][icache_cfg_pkg::LINE_WORDS-1:0] data_i,

    input  wire                         done_i,
    input  icache_cfg_pkg::word_t       fill_word_i,

    output logic                        hit_o,
    output logic                        advance_o,

    output icache_cfg_pkg::fetch_resp_t resp_o,
    output logic                        resp_valid_o,
    input  wire                         resp_ready_i
);

    logic [icache_cfg_pkg::WAYS-1:0] match;
    icache_cfg_pkg::word_t           hit_word;
    icache_cfg_pkg::word_t           load_word;
    logic                            is_fetch;
    logic                            resp_free;
    logic                            load;
    icache_cfg_pkg::fetch_resp_t     resp_q;
    logic                            resp_valid_q;

    assign is_fetch = (dec_req_i.op == icache_cfg_pkg::OP_FETCH);

    always_comb begin
        hit_word = data_i[0][icache_cfg_pkg::addr_offset(dec_req_i.addr)];
        for (int w = 0; w < icache_cfg_pkg::WAYS; w++) begin
            match[w] = valid_i[w]
                       && (tag_i[w] == icache_cfg_pkg::addr_tag(dec_req_i.addr));
            if (match[w]) begin
                hit_word = data_i[w][icache_cfg_pkg::addr_offset(dec_req_i.addr)];
            end
        end
    end

    assign hit_o     = dec_valid_i && is_fetch && (|match);
    assign resp_free = !resp_valid_q || resp_ready_i;
    assign load      = resp_free && (hit_o || done_i);
    assign load_word = done_i ? fill_word_i : hit_word;

    // an invalidate leaves without a response
    assign advance_o = dec_valid_i && (!is_fetch || load);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid_q <= 1'b0;
        end else if (load) begin
            resp_valid_q <= 1'b1;
        end else if (resp_ready_i) begin
            resp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            resp_q.addr <= dec_req_i.addr;
            resp_q.inst <= load_word;
        end
    end

    assign resp_o       = resp_q;
    assign resp_valid_o = resp_valid_q;

endmodule

`default_nettype wire

// File: design/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

module icache_top (
    input  wire                         clk,
    input  wire                         rst_n,

    input  icache_cfg_pkg::fetch_req_t  req_i,
    input  wire                         req_valid_i,
    output logic                        req_ready_o,

    output icache_cfg_pkg::fetch_resp_t resp_o,
    output logic                        resp_valid_o,
    input  wire                         resp_ready_i,

    output icache_bus_pkg::wb_req_t     wb_o,
    input  icache_bus_pkg::wb_rsp_t     wb_i
);

    logic                       dec_valid;
    icache_cfg_pkg::fetch_req_t dec_req;
    icache_cfg_pkg::index_t     rd_index;
    icache_cfg_pkg::array_wr_t  array_wr;
    logic                       hit;
    logic                       advance;
    logic                       busy;
    logic                       done;
    icache_cfg_pkg::word_t      fill_word;

    icache_cfg_pkg::tag_t  [icache_cfg_pkg::WAYS-1:0] way_tag;
    logic                  [icache_cfg_pkg::WAYS-1:0] way_valid;
    icache_cfg_pkg::word_t [icache_cfg_pkg::WAYS-1:0][icache_cfg_pkg::LINE_WORDS-1:0] way_data;

    fetch_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_i       (req_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .advance_i   (advance),
        .busy_i      (busy),
        .dec_valid_o (dec_valid),
        .dec_req_o   (dec_req),
        .rd_index_o  (rd_index)
    );

    cache_ways u_ways (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_index_i (rd_index),
        .wr_i       (array_wr),
        .tag_o      (way_tag),
        .valid_o    (way_valid),
        .data_o     (way_data)
    );

    refill_ctrl u_refill (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec_valid_i (dec_valid),
        .dec_req_i   (dec_req),
        .hit_i       (hit),
        .busy_o      (busy),
        .done_o      (done),
        .fill_word_o (fill_word),
        .wr_o        (array_wr),
        .wb_o        (wb_o),
        .wb_i        (wb_i)
    );

    hit_select u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_valid_i  (dec_valid),
        .dec_req_i    (dec_req),
        .tag_i        (way_tag),
        .valid_i      (way_valid),
        .data_i       (way_data),
        .done_i       (done),
        .fill_word_i  (fill_word),
        .hit_o        (hit),
        .advance_o    (advance),
        .resp_o       (resp_o),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i)
    );

endmodule

`default_nettype wire

// File: dv/wb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module wb_mem_model #(
    parameter logic [31:0] PATTERN = 32'h5A5A_0F0F
) (
    input  wire                      clk,
    input  wire                      rst_n,

    input  icache_bus_pkg::wb_req_t  wb_i,
    output icache_bus_pkg::wb_rsp_t  wb_o,

    output logic [31:0]              cycles_o
);

    logic        ack_q;
    logic        cyc_q;
    logic [31:0] dat_q;
    logic [31:0] count_q;

    // ack one cycle after stb, then drop so the next beat waits again
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            cyc_q   <= 1'b0;
            count_q <= '0;
        end else begin
            ack_q <= wb_i.cyc && wb_i.stb && !ack_q;
            cyc_q <= wb_i.cyc;
            // one bus cycle per rising edge of cyc
            if (wb_i.cyc && !cyc_q) begin
                count_q <= count_q + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        dat_q <= wb_i.adr ^ PATTERN;
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = dat_q;
    assign cycles_o = count_q;

endmodule

`default_nettype wire

// File: dv/tb_icache.sv
`timescale 1ns/100ps
`default_nettype none

module tb_icache;

    localparam int          HALF_PERIOD   = 20;
    localparam int          SAMPLE_DELAY  = 5;
    localparam logic [31:0] DATA_PATTERN  = 32'h5A5A_0F0F;
    localparam int          REQ_TIMEOUT   = 200;
    localparam int          DRAIN_TIMEOUT = 2000;
    localparam int          RANDOM_REQS   = 300;
    localparam int          TB_SETS       = 64;
    localparam int          LINE_BYTES    = 16;

    logic                        clk;
    logic                        rst_n;
    icache_cfg_pkg::fetch_req_t  req;
    logic                        req_valid;
    logic                        req_ready;
    icache_cfg_pkg::fetch_resp_t resp;
    logic                        resp_valid;
    logic                        resp_ready;
    icache_bus_pkg::wb_req_t     wb_req;
    icache_bus_pkg::wb_rsp_t     wb_rsp;
    logic [31:0]                 bus_cycles;

    string                       test_name = "reset";
    int unsigned                 cycle = 0;
    icache_cfg_pkg::fetch_resp_t expq [$];
    int unsigned                 fetch_count = 0;
    int unsigned                 resp_count = 0;
    int unsigned                 accept_cycle = 0;
    int unsigned                 valid_since = 0;
    int unsigned                 last_valid_since = 0;
    logic                        rand_ready = 1'b0;
    logic [31:0]                 addr_rng = 32'd8;
    logic [31:0]                 ready_rng = 32'd8;

    // latest refilled line per set is certainly resident
    logic [31:0]                 known_line [TB_SETS];
    logic [TB_SETS-1:0]          known_vld = '0;
    logic                        last_accept_resident = 1'b0;
    logic                        bus_open = 1'b0;
    int unsigned                 beats = 0;
    logic [31:0]                 line_base = '0;
    // line of the latest accepted fetch
    logic [31:0]                 fetch_line = '0;

    logic                        prev_valid = 1'b0;
    logic                        prev_ready = 1'b0;
    icache_cfg_pkg::fetch_resp_t prev_resp = '0;

    icache_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_i        (req),
        .req_valid_i  (req_valid),
        .req_ready_o  (req_ready),
        .resp_o       (resp),
        .resp_valid_o (resp_valid),
        .resp_ready_i (resp_ready),
        .wb_o         (wb_req),
        .wb_i         (wb_rsp)
    );

    wb_mem_model #(
        .PATTERN (DATA_PATTERN)
    ) u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_i     (wb_req),
        .wb_o     (wb_rsp),
        .cycles_o (bus_cycles)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int line_index(input logic [31:0] addr);
        return int'((addr / LINE_BYTES) % TB_SETS);
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] addr);
        return addr & ~32'(LINE_BYTES - 1);
    endfunction

    // memory returns the word address xor the pattern
    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return (addr & ~32'h3) ^ DATA_PATTERN;
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_with(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        abort_run();
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (expected === actual) else begin
            $display("MISMATCH %s %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            abort_run();
        end
    endtask

    task automatic note_accept(input icache_cfg_pkg::op_t op, input logic [31:0] addr);
        icache_cfg_pkg::fetch_resp_t expected;
        int                          idx;
        idx          = line_index(addr);
        accept_cycle = cycle;
        if (op == icache_cfg_pkg::OP_FETCH) begin
            expected.addr = addr;
            expected.inst = model_word(addr);
            expq.push_back(expected);
            fetch_count++;
            fetch_line           = line_of(addr);
            last_accept_resident = known_vld[idx] && (known_line[idx] == line_of(addr));
        end else begin
            known_vld[idx]       = 1'b0;
            last_accept_resident = 1'b0;
        end
    endtask

    task automatic send_request(input icache_cfg_pkg::op_t op, input logic [31:0] addr);
        int waited;
        @(negedge clk);
        req.op    = op;
        req.addr  = addr;
        req_valid = 1'b1;
        waited    = 0;
        #SAMPLE_DELAY;
        while (!req_ready) begin
            if (waited == REQ_TIMEOUT) begin
                fail_with("request was not accepted before the timeout");
            end
            waited++;
            @(negedge clk);
            #SAMPLE_DELAY;
        end
        // transfers at the coming rising edge
        note_accept(op, addr);
    endtask

    task automatic drop_request();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (resp_count != fetch_count) begin
            if (waited == DRAIN_TIMEOUT) begin
                fail_with("responses did not arrive before the timeout");
            end
            waited++;
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // one refill is one bus cycle of four ascending beats
    task automatic watch_bus();
        if (wb_req.cyc) begin
            assert (wb_req.stb) else fail_with("stb low inside an open bus cycle");
            assert (!wb_req.we) else fail_with("write strobe seen on the refill bus");
            if (!bus_open) begin
                bus_open  = 1'b1;
                beats     = 0;
                line_base = fetch_line;
                assert (!last_accept_resident) else begin
                    fail_with("refill started for a line that is resident");
                end
            end
            if (wb_rsp.ack) begin
                check_value("refill address", line_base + beats * 4, wb_req.adr);
                beats++;
            end
        end else begin
            assert (!wb_req.stb) else fail_with("stb high while cyc is low");
            if (bus_open) begin
                bus_open = 1'b0;
                check_value("beats per bus cycle", 4, beats);
                known_line[line_index(line_base)] = line_base;
                known_vld[line_index(line_base)]  = 1'b1;
            end
        end
    endtask

    task automatic watch_response();
        logic                        held;
        icache_cfg_pkg::fetch_resp_t expected;
        held = prev_valid && !prev_ready;
        if (held) begin
            assert (resp_valid) else fail_with("resp_valid dropped before the response was taken");
            check_value("held response", prev_resp, resp);
        end
        if (resp_valid && !held) begin
            valid_since = cycle;
        end
        if (resp_valid && resp_ready) begin
            if (expq.size() == 0) begin
                fail_with("response arrived with no fetch outstanding");
            end
            expected = expq.pop_front();
            check_value("response address", expected.addr, resp.addr);
            check_value("response word", expected.inst, resp.inst);
            last_valid_since = valid_since;
            resp_count++;
        end
        prev_valid = resp_valid;
        prev_ready = resp_ready;
        prev_resp  = resp;
    endtask

    // back-pressure driver and monitors sample mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            if (rand_ready) begin
                ready_rng  = xorshift32(ready_rng);
                resp_ready = ready_rng[9];
            end else begin
                resp_ready = 1'b1;
            end
            #SAMPLE_DELAY;
            if (rst_n) begin
                watch_bus();
                watch_response();
            end
        end
    end

    task automatic run_cold_miss();
        logic [31:0] bus_before;
        test_name  = "cold_miss";
        bus_before = bus_cycles;
        send_request(icache_cfg_pkg::OP_FETCH, 32'h0000_1234);
        drop_request();
        wait_drain();
        check_value("bus cycles", bus_before + 1, bus_cycles);
    endtask

    task automatic run_hit();
        logic [31:0] bus_before;
        int unsigned first_accept;
        test_name  = "hit";
        bus_before = bus_cycles;
        send_request(icache_cfg_pkg::OP_FETCH, 32'h0000_123C);
        drop_request();
        wait_drain();
        check_value("hit latency", 2, last_valid_since - accept_cycle);
        // back to back hits accept one per cycle
        send_request(icache_cfg_pkg::OP_FETCH, 32'h0000_1230);
        first_accept = accept_cycle;
        send_request(icache_cfg_pkg::OP_FETCH, 32'h0000_1234);
        send_request(icache_cfg_pkg::OP_FETCH, 32'h0000_1238);
        drop_request();
        check_value("back to back accepts", 2, accept_cycle - first_accept);
        wait_drain();
        check_value("bus cycles", bus_before, bus_cycles);
    endtask

    task automatic run_invalidate();
        logic [31:0] bus_before;
        test_name  = "invalidate";
        bus_before = bus_cycles;
        send_request(icache_cfg_pkg::OP_INVAL, 32'h0000_1230);
        send_request(icache_cfg_pkg::OP_FETCH, 32'h0000_1238);
        drop_request();
        wait_drain();
        check_value("bus cycles", bus_before + 1, bus_cycles);
    endtask

    task automatic run_random();
        icache_cfg_pkg::op_t op;
        test_name  = "random";
        rand_ready = 1'b1;
        for (int i = 0; i < RANDOM_REQS; i++) begin
            addr_rng = xorshift32(addr_rng);
            if (addr_rng[27:26] == 2'b00) begin
                drop_request();
            end
            // a 4 KB window gives four tags per set
            if (addr_rng[31:28] == 4'h0) begin
                op = icache_cfg_pkg::OP_INVAL;
            end else begin
                op = icache_cfg_pkg::OP_FETCH;
            end
            send_request(op, {20'h0, addr_rng[11:2], 2'b00});
        end
        drop_request();
        wait_drain();
        rand_ready = 1'b0;
    endtask

    initial begin
        rst_n      = 1'b0;
        req        = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #SAMPLE_DELAY;
        assert (req_ready === 1'b1) else fail_with("req_ready not high after reset");
        assert (resp_valid === 1'b0) else fail_with("resp_valid not low after reset");
        assert (wb_req.cyc === 1'b0) else fail_with("cyc not low after reset");
        assert (wb_req.stb === 1'b0) else fail_with("stb not low after reset");

        run_cold_miss();
        run_hit();
        run_invalidate();
        run_random();

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
design/icache_cfg_pkg.sv
design/icache_bus_pkg.sv
design/fetch_decode.sv
design/cache_ways.sv
design/refill_ctrl.sv
design/hit_select.sv
design/icache_top.sv
dv/wb_mem_model.sv
dv/tb_icache.sv
